//--- decoder_config.svh
`ifndef DECODER_CONFIG_SVH
`define DECODER_CONFIG_SVH

// ------------------------------------------------------------------------
// SPI framing
// ------------------------------------------------------------------------

// bits per command or reply word
`define FRAME_BITS 16

// flops per SPI pin before edge detection
`define SYNC_STAGES 2

// ------------------------------------------------------------------------
// decoder constants
// ------------------------------------------------------------------------

`define REG0_DEFAULT 8'h12    // reg0 after reset or restore
`define REG1_DEFAULT 8'h34    // reg1 after reset or restore

// identifier reply word reading as ascii "yu"
`define DEVICE_ID 16'h7975

`define GET_FILLER 12'h123    // low bits for a get on an unknown address

`endif

//--- spiPkg.sv
`include "decoder_config.svh"

package spiPkg;

	// one SPI word sent msb first
	typedef logic [`FRAME_BITS-1:0] spiFrame_t;

	// raw pin sample taken through the synchronizer chain
	typedef struct packed {
		logic sck;
		logic mosi;
		logic csel;    // active low
	} pinSample_t;

	// received word strobe
	typedef struct packed {
		logic      valid;    // one cycle only
		spiFrame_t frame;
	} rxEvent_t;

	// reply word handed to the transmit side
	typedef struct packed {
		logic      load;    // one cycle only
		spiFrame_t frame;
	} txLoad_t;

endpackage

//--- cmdPkg.sv
package cmdPkg;

	typedef logic [3:0] regAddr_t;
	typedef logic [7:0] regValue_t;

	// ------------------------------------------------------------------------
	// command opcodes
	// ------------------------------------------------------------------------
	typedef enum logic [3:0] {
		setReg      = 4'd2,    // write reg by addr
		getReg      = 4'd3,    // read reg by addr
		restoreRegs = 4'd4,    // both regs back to defaults
		sendId      = 4'd6     // identifier word
	} opcode_e;

	// command frame layout from the msb down
	typedef struct packed {
		opcode_e   opcode;
		regAddr_t  addr;
		regValue_t value;
	} cmdWord_t;

	// test register addresses
	localparam regAddr_t reg0Addr = 4'd1;
	localparam regAddr_t reg1Addr = 4'd2;

	// decoder FSM states
	typedef enum logic [2:0] {
		idle,
		decode,
		setRegs,
		getRegs,
		restore,
		sendIdent,
		replyWait    // reply loaded and waiting for the host clock
	} decState_e;

endpackage

//--- spiFrameRx.sv
`timescale 1ns/10ps
`include "decoder_config.svh"

module spiFrameRx (
	input  logic             CLK,
	input  logic             CMD_RST,
	input  logic             SCK,
	input  logic             MOSI,
	input  logic             CSEL,        // active low
	output spiPkg::rxEvent_t rxEvent,
	output logic             cselRise     // end of any frame
);
	import spiPkg::*;

	// counter saturates one past a full frame
	localparam int countBits = $clog2(`FRAME_BITS + 2);
	localparam pinSample_t pinIdle = '{sck: 1'b0, mosi: 1'b0, csel: 1'b1};

	pinSample_t                    pinIn;
	pinSample_t [`SYNC_STAGES-1:0] pinSync;
	pinSample_t                    pinNow;     // synchronized pins
	logic                          sckPrev;
	logic                          cselPrev;
	logic                          sckRise;
	logic                          cselFall;
	logic                          cselEnd;
	logic                          inFrame;
	spiFrame_t                     shiftReg;
	logic [countBits-1:0]          bitCount;

	// ------------------------------------------------------------------------
	// pin synchronizer and edge detect
	// ------------------------------------------------------------------------
	assign pinIn = '{sck: SCK, mosi: MOSI, csel: CSEL};
	assign pinNow = pinSync[`SYNC_STAGES-1];

	always_ff @(posedge CLK) begin
		if (CMD_RST) begin
			pinSync  <= {`SYNC_STAGES{pinIdle}};
			sckPrev  <= 1'b0;
			cselPrev <= 1'b1;    // bus idle so no false fall
		end else begin
			pinSync  <= {pinSync[`SYNC_STAGES-2:0], pinIn};
			sckPrev  <= pinNow.sck;
			cselPrev <= pinNow.csel;
		end
	end

	assign sckRise  = pinNow.sck & ~sckPrev;
	assign cselFall = ~pinNow.csel & cselPrev;
	assign cselEnd  = pinNow.csel & ~cselPrev;
	assign inFrame  = ~pinNow.csel;

	// ------------------------------------------------------------------------
	// shift in and bit count
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (sckRise && inFrame)
			shiftReg <= {shiftReg[`FRAME_BITS-2:0], pinNow.mosi};    // msb first
	end

	always_ff @(posedge CLK) begin
		if (CMD_RST || cselFall)
			bitCount <= '0;
		else if (sckRise && inFrame && bitCount <= countBits'(`FRAME_BITS))
			bitCount <= bitCount + 1'b1;
	end

	// word strobe only for exact length frames
	always_ff @(posedge CLK) begin
		if (CMD_RST) begin
			rxEvent.valid <= 1'b0;
			cselRise      <= 1'b0;
		end else begin
			rxEvent.valid <= cselEnd && (bitCount == countBits'(`FRAME_BITS));
			cselRise      <= cselEnd;
		end
		if (cselEnd)
			rxEvent.frame <= shiftReg;    // payload word
	end

endmodule

//--- commandDecoder.sv
`timescale 1ns/10ps
`include "decoder_config.svh"

module commandDecoder (
	input  logic             CLK,
	input  logic             CMD_RST,
	input  spiPkg::rxEvent_t rxEvent,
	input  logic             txBusy,
	output spiPkg::txLoad_t  reply
);
	import spiPkg::*;
	import cmdPkg::*;

	decState_e state;
	decState_e nextState;
	cmdWord_t  cmdWord;       // latched command
	regValue_t reg0;
	regValue_t reg1;
	spiFrame_t replyFrame;
	logic      replyLoad;

	// ------------------------------------------------------------------------
	// decoder FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (CMD_RST)
			state <= idle;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			idle: begin
				if (rxEvent.valid)
					nextState = decode;
			end
			decode: begin
				case (cmdWord.opcode)
					setReg:      nextState = setRegs;
					getReg:      nextState = getRegs;
					restoreRegs: nextState = restore;
					sendId:      nextState = sendIdent;
					default:     nextState = idle;    // unknown opcode dropped
				endcase
			end
			setRegs:   nextState = idle;
			restore:   nextState = idle;
			getRegs:   nextState = replyWait;
			sendIdent: nextState = replyWait;
			replyWait: begin
				// busy rises the cycle after load
				if (!txBusy)
					nextState = idle;
			end
			default:   nextState = idle;
		endcase
	end

	// catch the word only while idle
	always_ff @(posedge CLK) begin
		if (state == idle && rxEvent.valid)
			cmdWord <= cmdWord_t'(rxEvent.frame);
	end

	// ------------------------------------------------------------------------
	// test registers
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (CMD_RST || state == restore) begin
			reg0 <= `REG0_DEFAULT;
			reg1 <= `REG1_DEFAULT;
		end else if (state == setRegs) begin
			// write by address and ignore the rest
			if (cmdWord.addr == reg0Addr)
				reg0 <= cmdWord.value;
			else if (cmdWord.addr == reg1Addr)
				reg1 <= cmdWord.value;
		end
	end

	// ------------------------------------------------------------------------
	// reply builder
	// ------------------------------------------------------------------------
	always_comb begin
		replyFrame = '0;
		case (state)
			getRegs: begin
				if (cmdWord.addr == reg0Addr)
					replyFrame = {cmdWord.opcode, cmdWord.addr, reg0};
				else if (cmdWord.addr == reg1Addr)
					replyFrame = {cmdWord.opcode, cmdWord.addr, reg1};
				else
					replyFrame = {cmdWord.opcode, `GET_FILLER};    // unknown addr
			end
			sendIdent: replyFrame = `DEVICE_ID;
			default:   replyFrame = '0;
		endcase
	end

	// one cycle strobe per reply state
	assign replyLoad = (state == getRegs) || (state == sendIdent);

	assign reply = '{load: replyLoad, frame: replyFrame};

endmodule

//--- spiFrameTx.sv
`timescale 1ns/10ps
`include "decoder_config.svh"

module spiFrameTx (
	input  logic            CLK,
	input  logic            CMD_RST,
	input  logic            SCK,
	input  logic            CSEL,        // active low
	input  logic            cselRise,    // end of frame from rx side
	input  spiPkg::txLoad_t reply,
	output logic            txBusy,
	output logic            MISO
);
	import spiPkg::*;

	logic [`SYNC_STAGES-1:0] sckSync;
	logic [`SYNC_STAGES-1:0] cselSync;
	logic                    sckPrev;
	logic                    cselPrev;
	logic                    sckFall;
	logic                    cselFall;
	logic                    active;      // reply frame on the wire
	logic                    frameDone;
	spiFrame_t               shiftReg;

	// ------------------------------------------------------------------------
	// local synchronizer for edge timing
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (CMD_RST) begin
			sckSync  <= '0;
			cselSync <= '1;
			sckPrev  <= 1'b0;
			cselPrev <= 1'b1;
		end else begin
			sckSync  <= {sckSync[`SYNC_STAGES-2:0], SCK};
			cselSync <= {cselSync[`SYNC_STAGES-2:0], CSEL};
			sckPrev  <= sckSync[`SYNC_STAGES-1];
			cselPrev <= cselSync[`SYNC_STAGES-1];
		end
	end

	assign sckFall   = sckPrev & ~sckSync[`SYNC_STAGES-1];
	assign cselFall  = cselPrev & ~cselSync[`SYNC_STAGES-1];
	assign frameDone = cselRise & active;    // only the frame we drove

	// ------------------------------------------------------------------------
	// busy and frame tracking
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (CMD_RST || frameDone) begin
			txBusy <= 1'b0;
			active <= 1'b0;
		end else begin
			if (reply.load)
				txBusy <= 1'b1;
			// a frame already open at load time is skipped
			if (cselFall && txBusy)
				active <= 1'b1;
		end
	end

	// reply shift register sends msb first
	always_ff @(posedge CLK) begin
		if (reply.load)
			shiftReg <= reply.frame;
		else if (frameDone)
			shiftReg <= '0;
		else if (active && sckFall)
			shiftReg <= {shiftReg[`FRAME_BITS-2:0], 1'b0};    // next bit after falling sck
	end

	assign MISO = active & shiftReg[`FRAME_BITS-1];    // low with no reply

endmodule

//--- commandDecoderTop.sv
`timescale 1ns/10ps

module commandDecoderTop (
	input  logic CLK,
	input  logic CMD_RST,
	input  logic SCK,
	input  logic MOSI,
	input  logic CSEL,    // active low
	output logic MISO
);
	import spiPkg::*;

	rxEvent_t rxEvent;     // received word strobe
	txLoad_t  reply;       // reply word strobe
	logic     cselRise;
	logic     txBusy;

	// ------------------------------------------------------------------------
	// input side
	// ------------------------------------------------------------------------
	spiFrameRx u_spiFrameRx (
		.CLK      (CLK),
		.CMD_RST  (CMD_RST),
		.SCK      (SCK),
		.MOSI     (MOSI),
		.CSEL     (CSEL),
		.rxEvent  (rxEvent),
		.cselRise (cselRise)
	);

	// decoder FSM and test registers
	commandDecoder u_commandDecoder (
		.CLK     (CLK),
		.CMD_RST (CMD_RST),
		.rxEvent (rxEvent),
		.txBusy  (txBusy),
		.reply   (reply)
	);

	// ------------------------------------------------------------------------
	// output side
	// ------------------------------------------------------------------------
	spiFrameTx u_spiFrameTx (
		.CLK      (CLK),
		.CMD_RST  (CMD_RST),
		.SCK      (SCK),
		.CSEL     (CSEL),
		.cselRise (cselRise),
		.reply    (reply),
		.txBusy   (txBusy),
		.MISO     (MISO)
	);

endmodule

//--- tbClockGen.sv
`timescale 1ns/10ps

module tbClockGen #(
	parameter real periodNs = 4.0    // full CLK period
) (
	output logic CLK
);

	// free running clock that starts low
	initial begin
		CLK = 1'b0;
	end

	always begin
		#(periodNs / 2.0);
		CLK = ~CLK;    // toggle every half period
	end

endmodule

//--- tbCommandDecoder.sv
`timescale 1ns/10ps

module tbCommandDecoder;

	localparam int halfSck     = 8;        // CLK cycles per SCK phase
	localparam int minGap      = 16;       // idle CLK cycles after CSEL rises
	localparam int maxGapExtra = 8;        // random part of the gap
	localparam int maxEntries  = 32;       // golden table rows
	localparam int idleTimeout = 64;       // cycles for MISO to go low
	localparam int runTimeout  = 60000;    // whole run limit in CLK cycles

	logic        CLK;
	logic        CMD_RST;
	logic        SCK;
	logic        MOSI;
	logic        CSEL;       // active low
	logic        MISO;
	logic [15:0] golden [0:3*maxEntries-1];    // three words per golden row

	tbClockGen #(.periodNs(4.0)) u_tbClockGen (.CLK(CLK));

	commandDecoderTop u_commandDecoderTop (
		.CLK     (CLK),
		.CMD_RST (CMD_RST),
		.SCK     (SCK),
		.MOSI    (MOSI),
		.CSEL    (CSEL),
		.MISO    (MISO)
	);

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkValue(input string name, input logic [15:0] got,
		input logic [15:0] expected);
		if (got !== expected)
			failRun($sformatf("mismatch at %0t: %s got %h expected %h",
				$realtime, name, got, expected));
	endtask

	// all waits end on a falling edge where inputs change
	task automatic waitCycles(input int count);
		int idx;
		for (idx = 0; idx < count; idx++)
			@(negedge CLK);
	endtask

	task automatic idleGap();
		int gap;
		gap = minGap + int'($urandom % maxGapExtra);    // random extra spacing
		waitCycles(gap);
	endtask

	// MISO must drop once no reply is on the wire
	task automatic waitMisoIdle();
		int count;
		for (count = 0; count < idleTimeout && MISO !== 1'b0; count++)
			@(negedge CLK);
		if (MISO !== 1'b0)
			failRun("MISO stayed high after the end of a frame");
	endtask

	// one full SPI frame msb first with MISO read as SCK rises
	task automatic transferFrame(input logic [15:0] txWord, output logic [15:0] rxWord);
		int bitIdx;
		rxWord = '0;
		CSEL = 1'b0;
		for (bitIdx = 15; bitIdx >= 0; bitIdx--) begin
			MOSI = txWord[bitIdx];    // set up during low phase
			waitCycles(halfSck);
			SCK = 1'b1;
			rxWord[bitIdx] = MISO;    // stable since the last SCK fall
			waitCycles(halfSck);
			SCK = 1'b0;
		end
		waitCycles(halfSck);
		CSEL = 1'b1;    // end of frame
		MOSI = 1'b0;
	endtask

	// ------------------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------------------
	initial begin
		for (int cycle = 0; cycle < runTimeout; cycle++)
			@(posedge CLK);
		failRun($sformatf("timeout, run exceeded %0d clock cycles", runTimeout));
	end

	// ------------------------------------------------------------------------
	// stimulus from the golden table
	// ------------------------------------------------------------------------
	initial begin
		int          entryIdx;
		logic [15:0] cmdWord;
		logic [15:0] flag;
		logic [15:0] expected;
		logic [15:0] captured;
		bit          done;

		CMD_RST = 1'b1;
		SCK     = 1'b0;
		MOSI    = 1'b0;
		CSEL    = 1'b1;    // bus idle
		done    = 1'b0;
		void'($urandom(21821));
		$readmemh("commandGolden.mem", golden);

		waitCycles(4);    // reset over four rising edges
		CMD_RST = 1'b0;
		waitCycles(2);
		checkValue("MISO after reset", {15'd0, MISO}, 16'h0000);

		for (entryIdx = 0; entryIdx < maxEntries && !done; entryIdx++) begin
			cmdWord  = golden[3*entryIdx];
			flag     = golden[3*entryIdx+1];
			expected = golden[3*entryIdx+2];
			if (flag == 16'h000e) begin
				done = 1'b1;    // end marker
			end else begin
				if (flag > 16'h0001)
					failRun($sformatf("golden row %0d holds an unknown reply flag", entryIdx));
				waitMisoIdle();
				idleGap();
				transferFrame(cmdWord, captured);
				if (flag == 16'h0001) begin
					// all zero frame clocks the reply out
					idleGap();
					transferFrame(16'h0000, captured);
					checkValue($sformatf("MISO reply to %h", cmdWord), captured, expected);
				end
			end
		end

		if (!done) begin
			failRun("golden file has no end marker");
		end else begin
			waitCycles(minGap);
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

//--- commandGolden.mem
// columns: command word, reply flag (0 none, 1 reply, e end), expected reply word
// reply is read back on an all zero frame sent after the command
3100 0001 3112
3200 0001 3234
21a5 0000 0000
3100 0001 31a5
3200 0001 3234
225c 0000 0000
4000 0000 0000
3100 0001 3112
3200 0001 3234
6000 0001 7975
3500 0001 3123
27ee 0000 0000
3100 0001 3112
3200 0001 3234
7000 0001 0000
3200 0001 3234
0000 000e 0000

//--- compile.f
+incdir+.
spiPkg.sv
cmdPkg.sv
spiFrameRx.sv
commandDecoder.sv
spiFrameTx.sv
commandDecoderTop.sv
tbClockGen.sv
tbCommandDecoder.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -Wno-fatal \
	--top-module tbCommandDecoder -f compile.f -o VtbCommandDecoder

simOut=$(./obj_dir/VtbCommandDecoder 2>&1) || true
echo "$simOut"

if echo "$simOut" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
